//--- tb.f
logic/rv_pkg.sv
logic/regfile.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/pipeline_core.sv
verification/tb_memory.sv
verification/core_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module core_tb \
		-Mdir obj_dir -o core_tb

run: compile
	./obj_dir/core_tb | tee run.log
	grep -q "All checks passed" run.log

clean:
	rm -rf obj_dir run.log

//--- verification/core_tb.sv
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_stores = 23;
    localparam int prog_len = 69;
    // 40 cycles per instruction times the worst wait of 4
    localparam int wd_cycles = prog_len * 40 * 4;

    logic           clk;
    logic           arst_n;
    rv_pkg::rv_word inst_rdata;
    logic           inst_resp;
    rv_pkg::rv_word inst_addr;
    logic           inst_read;
    rv_pkg::rv_word data_rdata;
    logic           data_resp;
    rv_pkg::rv_word data_addr;
    rv_pkg::rv_word data_wdata;
    logic [3:0]     data_mbe;
    logic           data_read;
    logic           data_write;

    rv_pkg::rv_word exp_addr [n_stores];
    rv_pkg::rv_word exp_data [n_stores];
    logic [63:0]    store_log [$];
    int             store_count = 0;
    int             reset_errs = 0;
    int             fetch_errs = 0;
    int             store_errs = 0;
    int             mbe_errs = 0;
    int             final_errs = 0;

    always #5 clk = ~clk;

    pipeline_core pipeline_core_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .inst_addr  (inst_addr),
        .inst_read  (inst_read),
        .data_rdata (data_rdata),
        .data_resp  (data_resp),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_mbe   (data_mbe),
        .data_read  (data_read),
        .data_write (data_write)
    );

    tb_memory memory_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_addr  (inst_addr),
        .inst_read  (inst_read),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_mbe   (data_mbe),
        .data_read  (data_read),
        .data_write (data_write),
        .data_rdata (data_rdata),
        .data_resp  (data_resp)
    );

    // store monitor
    always @(posedge clk) begin
        if (arst_n && data_write && data_resp) begin
            store_log.push_back({data_addr, data_wdata});
            store_count <= store_count + 1;
        end
    end

    reset_check: assert property (@(posedge clk)
        (!arst_n || !$past(arst_n)) |-> (!data_read && !data_write && inst_addr == 32'h0))
    else begin
        reset_errs++;
        $display("ERR %0t: bus not idle around reset, inst_addr %h", $time, inst_addr);
    end

    fetch_check: assert property (@(posedge clk) disable iff (!arst_n) inst_read)
    else begin
        fetch_errs++;
        $display("ERR %0t: inst_read low out of reset", $time);
    end

    store_check: assert property (@(posedge clk) disable iff (!arst_n)
        (data_write && data_resp) |-> (store_count < n_stores
            && data_addr == exp_addr[store_count] && data_wdata == exp_data[store_count]))
    else begin
        store_errs++;
        $display("ERR %0t: store %0d to %h with %h does not match", $time, store_count,
                 data_addr, data_wdata);
    end

    mbe_check: assert property (@(posedge clk) disable iff (!arst_n)
        data_write |-> data_mbe == 4'b1111)
    else begin
        mbe_errs++;
        $display("ERR %0t: write byte enables %b", $time, data_mbe);
    end

    initial begin
        #(wd_cycles * 10);
        $display("timeout: the program did not complete its stores in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        int total;
        // values from the RV32I rules applied by hand
        exp_addr[0] = 32'd256;
        exp_data[0] = 32'd17;
        exp_addr[1] = 32'd260;
        exp_data[1] = 32'd384;
        exp_addr[2] = 32'd264;
        exp_data[2] = 32'hffff_fffe;
        exp_addr[3] = 32'd268;
        exp_data[3] = 32'd1;
        exp_addr[4] = 32'd272;
        exp_data[4] = 32'hffff_fe7e;
        exp_addr[5] = 32'd276;
        exp_data[5] = 32'h1234_5000;
        exp_addr[6] = 32'd280;
        exp_data[6] = 32'h0000_1028;
        exp_addr[7] = 32'd284;
        exp_data[7] = 32'd12;
        exp_addr[8] = 32'd288;
        exp_data[8] = 32'd17;
        // fall-through blocks 1, 3, 5, 7, 9, 11
        for (int k = 0; k < 6; k++) begin
            exp_addr[9 + 2 * k]  = 32'd320 + 32'(16 * k + 8);
            exp_data[9 + 2 * k]  = 32'd5;
            exp_addr[10 + 2 * k] = 32'd324 + 32'(16 * k + 8);
            exp_data[10 + 2 * k] = 32'd1;
        end
        exp_addr[21] = 32'd416;
        exp_data[21] = 32'd240;
        exp_addr[22] = 32'd420;
        exp_data[22] = 32'd260;

        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n <= 1'b1;

        wait (store_count == n_stores);
        // room for any extra store to show up
        repeat (10) @(posedge clk);
        @(negedge clk);
        if (store_log.size() != n_stores) begin
            final_errs++;
            $display("ERR %0t: %0d stores seen, %0d expected", $time, store_log.size(),
                     n_stores);
        end
        for (int k = 0; k < n_stores && k < store_log.size(); k++) begin
            assert (store_log[k] == {exp_addr[k], exp_data[k]})
            else begin
                final_errs++;
                $display("ERR %0t: logged store %0d is %h, expected %h", $time, k,
                         store_log[k], {exp_addr[k], exp_data[k]});
            end
        end

        total = reset_errs + fetch_errs + store_errs + mbe_errs + final_errs;
        $display("errors: reset %0d, fetch %0d, store %0d, mbe %0d, log %0d", reset_errs,
                 fetch_errs, store_errs, mbe_errs, final_errs);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_memory.sv
`default_nettype none

module tb_memory (
    input  logic           clk,
    input  logic           arst_n,
    input  rv_pkg::rv_word inst_addr,
    input  logic           inst_read,
    output rv_pkg::rv_word inst_rdata,
    output logic           inst_resp,
    input  rv_pkg::rv_word data_addr,
    input  rv_pkg::rv_word data_wdata,
    input  logic [3:0]     data_mbe,
    input  logic           data_read,
    input  logic           data_write,
    output rv_pkg::rv_word data_rdata,
    output logic           data_resp
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] lfsr_seed = 32'h143a;

    rv_pkg::rv_word imem [256];
    rv_pkg::rv_word dmem [256];
    logic [31:0]    lfsr;
    logic [1:0]     i_left;
    logic [1:0]     d_left;
    logic           i_busy;
    logic           d_busy;

    function automatic rv_pkg::rv_word i_format(input int op, input int rd, input int f3,
                                                input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic rv_pkg::rv_word r_format(input int f7, input int rd, input int f3,
                                                input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_pkg::rv_word s_format(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv_pkg::rv_word b_format(input int f3, input int rs1, input int rs2,
                                                input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic rv_pkg::rv_word u_format(input int op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic rv_pkg::rv_word j_format(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // two bits with one step each
    task automatic next_wait(output logic [1:0] w);
        lfsr = lfsr_step(lfsr);
        w[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        w[1] = lfsr[0];
    endtask

    initial begin
        int f3s [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
        int ra [12]  = '{1, 1, 1, 1, 6, 1, 1, 6, 1, 6, 6, 1};
        int rb [12]  = '{1, 6, 6, 1, 1, 6, 6, 1, 6, 1, 1, 6};
        for (int i = 0; i < 256; i++) begin
            imem[i] = i_format('h13, 0, 0, 0, i);
            dmem[i] = 32'hdada_0000 + i;
        end
        // dependent ALU chain
        imem[0]  = i_format('h13, 1, 0, 0, 5);
        imem[1]  = i_format('h13, 2, 0, 1, 7);
        imem[2]  = r_format(0, 3, 0, 1, 2);
        imem[3]  = r_format('h20, 4, 0, 3, 1);
        imem[4]  = r_format(0, 5, 1, 4, 1);
        imem[5]  = i_format('h13, 6, 0, 0, -64);
        imem[6]  = r_format('h20, 7, 5, 6, 1);
        imem[7]  = r_format(0, 8, 3, 1, 6);
        imem[8]  = r_format(0, 9, 4, 7, 5);
        imem[9]  = u_format('h37, 10, 'h12345);
        imem[10] = u_format('h17, 11, 1);
        imem[11] = i_format('h13, 20, 0, 0, 'h100);
        imem[12] = s_format(3, 20, 0);
        imem[13] = s_format(5, 20, 4);
        imem[14] = s_format(7, 20, 8);
        imem[15] = s_format(8, 20, 12);
        imem[16] = s_format(9, 20, 16);
        imem[17] = s_format(10, 20, 20);
        imem[18] = s_format(11, 20, 24);
        // store then load back and use at once
        imem[19] = s_format(4, 20, 28);
        imem[20] = i_format('h03, 12, 2, 20, 28);
        imem[21] = r_format(0, 13, 0, 12, 1);
        imem[22] = s_format(13, 20, 32);
        // even blocks are taken and odd blocks fall through
        for (int b = 0; b < 12; b++) begin
            imem[23 + 3 * b] = b_format(f3s[b], ra[b], rb[b], 12);
            imem[24 + 3 * b] = s_format(1, 20, 64 + 8 * b);
            imem[25 + 3 * b] = s_format(8, 20, 68 + 8 * b);
        end
        imem[59] = j_format(14, 12);
        imem[60] = s_format(1, 20, 500);
        imem[61] = s_format(1, 20, 500);
        imem[62] = s_format(14, 20, 160);
        // jalr drops bit 0 of the odd target
        imem[63] = i_format('h13, 15, 0, 0, 269);
        imem[64] = i_format('h67, 16, 0, 15, 0);
        imem[65] = s_format(1, 20, 500);
        imem[66] = s_format(1, 20, 500);
        imem[67] = s_format(16, 20, 164);
        imem[68] = j_format(0, 0);
    end

    always @(negedge clk or negedge arst_n) begin
        logic [1:0] w;
        if (!arst_n) begin
            lfsr       = lfsr_seed;
            i_busy     = 1'b0;
            d_busy     = 1'b0;
            i_left     = 2'd0;
            d_left     = 2'd0;
            inst_resp  <= 1'b0;
            data_resp  <= 1'b0;
            inst_rdata <= '0;
            data_rdata <= '0;
        end else begin
            if (inst_read) begin
                if (!i_busy) begin
                    next_wait(w);
                    i_left = w;
                end
                if (i_left == 2'd0) begin
                    inst_resp  <= 1'b1;
                    inst_rdata <= imem[inst_addr[9:2]];
                    i_busy = 1'b0;
                end else begin
                    inst_resp <= 1'b0;
                    i_left = i_left - 2'd1;
                    i_busy = 1'b1;
                end
            end else begin
                inst_resp <= 1'b0;
                i_busy = 1'b0;
            end
            if (data_read || data_write) begin
                if (!d_busy) begin
                    next_wait(w);
                    d_left = w;
                end
                if (d_left == 2'd0) begin
                    data_resp  <= 1'b1;
                    data_rdata <= dmem[data_addr[9:2]];
                    d_busy = 1'b0;
                end else begin
                    data_resp <= 1'b0;
                    d_left = d_left - 2'd1;
                    d_busy = 1'b1;
                end
            end else begin
                data_resp <= 1'b0;
                d_busy = 1'b0;
            end
        end
    end

    // write lands on the handshake edge
    always @(posedge clk) begin
        if (data_write && data_resp) begin
            for (int b = 0; b < 4; b++) begin
                if (data_mbe[b]) begin
                    dmem[data_addr[9:2]][8 * b +: 8] <= data_wdata[8 * b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/pipeline_core.sv
`default_nettype none

module pipeline_core (
    input  logic           clk,
    input  logic           arst_n,
    input  rv_pkg::rv_word inst_rdata,
    input  logic           inst_resp,
    output rv_pkg::rv_word inst_addr,
    output logic           inst_read,
    input  rv_pkg::rv_word data_rdata,
    input  logic           data_resp,
    output rv_pkg::rv_word data_addr,
    output rv_pkg::rv_word data_wdata,
    output logic [3:0]     data_mbe,
    output logic           data_read,
    output logic           data_write
);

    rv_pkg::rv_word     pc;
    rv_pkg::rv_word     if_id_instr;
    rv_pkg::rv_word     if_id_pc;
    logic               if_id_valid;
    rv_pkg::ctrl_word_s dec_ctrl;
    rv_pkg::rv_word     dec_rs1_data;
    rv_pkg::rv_word     dec_rs2_data;
    rv_pkg::ctrl_word_s id_ex_ctrl;
    rv_pkg::rv_word     id_ex_rs1_data;
    rv_pkg::rv_word     id_ex_rs2_data;
    rv_pkg::rv_word     alu_result;
    rv_pkg::rv_word     store_data;
    rv_pkg::rv_word     redirect_pc;
    logic               redirect;
    rv_pkg::ex_mem_s    ex_mem;
    rv_pkg::ex_mem_s    ex_mem_next;
    rv_pkg::ex_mem_s    mem_bus;
    rv_pkg::mem_wb_s    mem_wb;
    rv_pkg::mem_wb_s    mem_wb_next;
    rv_pkg::rv_word     wb_data;
    rv_pkg::rv_word     mem_rdata;
    rv_pkg::rv_word     load_hold;
    logic               mem_done;
    logic               stall;
    logic               load_use;

    assign inst_read = 1'b1;
    assign inst_addr = pc;

    // whole pipeline waits on either outstanding response
    assign stall = !inst_resp || ((data_read || data_write) && !data_resp);

    assign load_use = if_id_valid && id_ex_ctrl.mem_read && id_ex_ctrl.rd != '0
                      && (id_ex_ctrl.rd == dec_ctrl.rs1 || id_ex_ctrl.rd == dec_ctrl.rs2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= rv_pkg::reset_pc;
        end else if (!stall) begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (!load_use) begin
                pc <= pc + rv_pkg::pc_step;
            end
        end
    end

    // IF/ID, a squash turns the slot into a nop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id_instr <= rv_pkg::nop_instr;
            if_id_pc    <= rv_pkg::reset_pc;
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            if (redirect) begin
                if_id_instr <= rv_pkg::nop_instr;
                if_id_valid <= 1'b0;
            end else if (!load_use) begin
                if_id_instr <= inst_rdata;
                if_id_pc    <= pc;
                if_id_valid <= 1'b1;
            end
        end
    end

    decode_stage decode_stage_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .instr    (if_id_instr),
        .pc       (if_id_pc),
        .valid    (if_id_valid),
        .wb_en    (mem_wb.reg_write),
        .wb_rd    (mem_wb.rd),
        .wb_data  (wb_data),
        .ctrl     (dec_ctrl),
        .rs1_data (dec_rs1_data),
        .rs2_data (dec_rs2_data)
    );

    // ID/EX takes a bubble on squash or load-use
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex_ctrl <= '0;
        end else if (!stall) begin
            id_ex_ctrl <= (redirect || load_use) ? '0 : dec_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_ex_rs1_data <= dec_rs1_data;
            id_ex_rs2_data <= dec_rs2_data;
        end
    end

    execute_stage execute_stage_i (
        .ctrl        (id_ex_ctrl),
        .rs1_data    (id_ex_rs1_data),
        .rs2_data    (id_ex_rs2_data),
        .fwd_mem     (ex_mem),
        .fwd_wb      (mem_wb),
        .wb_data     (wb_data),
        .alu_result  (alu_result),
        .store_data  (store_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    always_comb begin
        ex_mem_next.rd         = id_ex_ctrl.rd;
        ex_mem_next.reg_write  = id_ex_ctrl.reg_write;
        ex_mem_next.mem_read   = id_ex_ctrl.mem_read;
        ex_mem_next.mem_write  = id_ex_ctrl.mem_write;
        ex_mem_next.wb_sel     = id_ex_ctrl.wb_sel;
        ex_mem_next.alu_result = alu_result;
        ex_mem_next.store_data = store_data;
        ex_mem_next.pc_plus4   = id_ex_ctrl.pc + rv_pkg::pc_step;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem <= ex_mem_next;
        end
    end

    // a data access answered while fetch still waits must not be issued again
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_done <= 1'b0;
        end else if (!stall) begin
            mem_done <= 1'b0;
        end else if ((data_read || data_write) && data_resp) begin
            mem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_read && data_resp) begin
            load_hold <= data_rdata;
        end
    end

    always_comb begin
        mem_bus = ex_mem;
        if (mem_done) begin
            mem_bus.mem_read  = 1'b0;
            mem_bus.mem_write = 1'b0;
        end
    end

    assign mem_rdata = mem_done ? load_hold : data_rdata;

    result_stage result_stage_i (
        .mem        (mem_bus),
        .data_rdata (mem_rdata),
        .wb_reg     (mem_wb),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_mbe   (data_mbe),
        .data_read  (data_read),
        .data_write (data_write),
        .wb         (mem_wb_next),
        .wb_data    (wb_data)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else if (!stall) begin
            mem_wb <= mem_wb_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/result_stage.sv
`default_nettype none

module result_stage (
    input  rv_pkg::ex_mem_s mem,
    input  rv_pkg::rv_word  data_rdata,
    input  rv_pkg::mem_wb_s wb_reg,
    output rv_pkg::rv_word  data_addr,
    output rv_pkg::rv_word  data_wdata,
    output logic [3:0]      data_mbe,
    output logic            data_read,
    output logic            data_write,
    output rv_pkg::mem_wb_s wb,
    output rv_pkg::rv_word  wb_data
);

    // data bus straight from the memory-stage entry
    assign data_read  = mem.mem_read;
    assign data_write = mem.mem_write;
    assign data_addr  = mem.alu_result;
    assign data_wdata = mem.store_data;
    assign data_mbe   = mem.mem_write ? rv_pkg::word_mbe : 4'b0000;

    always_comb begin
        wb.rd         = mem.rd;
        wb.reg_write  = mem.reg_write;
        wb.wb_sel     = mem.wb_sel;
        wb.alu_result = mem.alu_result;
        wb.pc_plus4   = mem.pc_plus4;
        // only meaningful for loads
        wb.load_data  = data_rdata;
    end

    always_comb begin
        case (wb_reg.wb_sel)
            rv_pkg::wb_load: wb_data = wb_reg.load_data;
            rv_pkg::wb_pc4:  wb_data = wb_reg.pc_plus4;
            default:         wb_data = wb_reg.alu_result;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`default_nettype none

module execute_stage (
    input  rv_pkg::ctrl_word_s ctrl,
    input  rv_pkg::rv_word     rs1_data,
    input  rv_pkg::rv_word     rs2_data,
    input  rv_pkg::ex_mem_s    fwd_mem,
    input  rv_pkg::mem_wb_s    fwd_wb,
    input  rv_pkg::rv_word     wb_data,
    output rv_pkg::rv_word     alu_result,
    output rv_pkg::rv_word     store_data,
    output logic               redirect,
    output rv_pkg::rv_word     redirect_pc
);

    rv_pkg::rv_word mem_value;
    rv_pkg::rv_word rs1_val;
    rv_pkg::rv_word rs2_val;
    rv_pkg::rv_word op_a;
    rv_pkg::rv_word op_b;
    rv_pkg::rv_word jalr_sum;
    logic           taken;

    // newest producer wins, x0 never forwards
    function automatic rv_pkg::rv_word forward(
        input rv_pkg::reg_idx  rs,
        input rv_pkg::rv_word  reg_value,
        input rv_pkg::ex_mem_s mem,
        input rv_pkg::rv_word  mem_val,
        input rv_pkg::mem_wb_s wb,
        input rv_pkg::rv_word  wb_val
    );
        rv_pkg::rv_word value;
        value = reg_value;
        if (rs != '0 && mem.reg_write && mem.rd == rs) begin
            value = mem_val;
        end else if (rs != '0 && wb.reg_write && wb.rd == rs) begin
            value = wb_val;
        end
        return value;
    endfunction

    // a load never sits here with a matching consumer, the interlock sees to that
    assign mem_value = (fwd_mem.wb_sel == rv_pkg::wb_pc4) ? fwd_mem.pc_plus4
                                                          : fwd_mem.alu_result;

    always_comb begin
        rs1_val = forward(ctrl.rs1, rs1_data, fwd_mem, mem_value, fwd_wb, wb_data);
        rs2_val = forward(ctrl.rs2, rs2_data, fwd_mem, mem_value, fwd_wb, wb_data);
    end

    assign op_a = (ctrl.a_sel == rv_pkg::a_pc) ? ctrl.pc : rs1_val;
    assign op_b = (ctrl.b_sel == rv_pkg::b_imm) ? ctrl.imm : rs2_val;
    assign store_data = rs2_val;

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::alu_add:    alu_result = op_a + op_b;
            rv_pkg::alu_sub:    alu_result = op_a - op_b;
            rv_pkg::alu_sll:    alu_result = op_a << op_b[4:0];
            rv_pkg::alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu:   alu_result = {31'b0, op_a < op_b};
            rv_pkg::alu_xor:    alu_result = op_a ^ op_b;
            rv_pkg::alu_srl:    alu_result = op_a >> op_b[4:0];
            rv_pkg::alu_sra:    alu_result = rv_pkg::rv_word'($signed(op_a) >>> op_b[4:0]);
            rv_pkg::alu_or:     alu_result = op_a | op_b;
            rv_pkg::alu_and:    alu_result = op_a & op_b;
            rv_pkg::alu_pass_b: alu_result = op_b;
            default:            alu_result = op_a + op_b;
        endcase
    end

    // branch compare on the forwarded sources
    always_comb begin
        case (ctrl.cmp_op)
            rv_pkg::cmp_beq:  taken = rs1_val == rs2_val;
            rv_pkg::cmp_bne:  taken = rs1_val != rs2_val;
            rv_pkg::cmp_blt:  taken = $signed(rs1_val) < $signed(rs2_val);
            rv_pkg::cmp_bge:  taken = $signed(rs1_val) >= $signed(rs2_val);
            rv_pkg::cmp_bltu: taken = rs1_val < rs2_val;
            rv_pkg::cmp_bgeu: taken = rs1_val >= rs2_val;
            default:          taken = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_val + ctrl.imm;
    assign redirect_pc = ctrl.is_jalr ? {jalr_sum[31:1], 1'b0} : ctrl.pc + ctrl.imm;
    assign redirect = ctrl.valid
                      && (ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && taken));

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  rv_pkg::rv_word     instr,
    input  rv_pkg::rv_word     pc,
    input  logic               valid,
    input  logic               wb_en,
    input  rv_pkg::reg_idx     wb_rd,
    input  rv_pkg::rv_word     wb_data,
    output rv_pkg::ctrl_word_s ctrl,
    output rv_pkg::rv_word     rs1_data,
    output rv_pkg::rv_word     rs2_data
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    rv_pkg::rv_word  imm_i;
    rv_pkg::rv_word  imm_s;
    rv_pkg::rv_word  imm_b;
    rv_pkg::rv_word  imm_u;
    rv_pkg::rv_word  imm_j;

    // OP and OP-IMM share the funct3 map
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  op = rv_pkg::alu_sll;
            3'b010:  op = rv_pkg::alu_slt;
            3'b011:  op = rv_pkg::alu_sltu;
            3'b100:  op = rv_pkg::alu_xor;
            3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  op = rv_pkg::alu_or;
            default: op = rv_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.pc     = pc;
        ctrl.valid  = valid;
        ctrl.rd     = instr[11:7];
        ctrl.cmp_op = rv_pkg::cmp_op_e'(funct3);
        ctrl.alu_op = rv_pkg::alu_add;
        ctrl.a_sel  = rv_pkg::a_rs1;
        ctrl.b_sel  = rv_pkg::b_imm;
        ctrl.wb_sel = rv_pkg::wb_alu;
        // source indices stay zero when a format has no such field
        case (opcode)
            rv_pkg::op_lui: begin
                ctrl.alu_op    = rv_pkg::alu_pass_b;
                ctrl.imm       = imm_u;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_auipc: begin
                ctrl.a_sel     = rv_pkg::a_pc;
                ctrl.imm       = imm_u;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_jal: begin
                ctrl.imm       = imm_j;
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_pc4;
            end
            rv_pkg::op_jalr: begin
                ctrl.rs1       = instr[19:15];
                ctrl.imm       = imm_i;
                ctrl.is_jalr   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_pc4;
            end
            rv_pkg::op_br: begin
                ctrl.rs1       = instr[19:15];
                ctrl.rs2       = instr[24:20];
                ctrl.imm       = imm_b;
                ctrl.is_branch = 1'b1;
            end
            rv_pkg::op_load: begin
                ctrl.rs1       = instr[19:15];
                ctrl.imm       = imm_i;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_load;
            end
            rv_pkg::op_store: begin
                ctrl.rs1       = instr[19:15];
                ctrl.rs2       = instr[24:20];
                ctrl.imm       = imm_s;
                ctrl.mem_write = 1'b1;
            end
            rv_pkg::op_imm: begin
                ctrl.rs1       = instr[19:15];
                ctrl.imm       = imm_i;
                ctrl.alu_op    = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::op_reg: begin
                ctrl.rs1       = instr[19:15];
                ctrl.rs2       = instr[24:20];
                ctrl.b_sel     = rv_pkg::b_rs2;
                ctrl.alu_op    = alu_sel(funct3, funct7[5]);
                ctrl.reg_write = 1'b1;
            end
            default: begin
                // unsupported, runs as a nop
                ctrl.rd = '0;
            end
        endcase
        if (!valid) begin
            ctrl.reg_write = 1'b0;
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.is_branch = 1'b0;
            ctrl.is_jal    = 1'b0;
            ctrl.is_jalr   = 1'b0;
        end
    end

    regfile regfile_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

//--- logic/regfile.sv
`default_nettype none

module regfile (
    input  logic           clk,
    input  logic           arst_n,
    input  rv_pkg::reg_idx rs1,
    input  rv_pkg::reg_idx rs2,
    output rv_pkg::rv_word rs1_data,
    output rv_pkg::rv_word rs2_data,
    input  logic           wb_en,
    input  rv_pkg::reg_idx wb_rd,
    input  rv_pkg::rv_word wb_data
);

    rv_pkg::rv_word regs [rv_pkg::num_regs];

    // x0 is never written so it stays at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rv_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // writeback value seen by decode in the same cycle
    assign rs1_data = (wb_en && rs1 != '0 && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (wb_en && rs2 != '0 && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] rv_word;
    typedef logic [4:0]  reg_idx;

    localparam rv_word reset_pc = 32'h0000_0000;
    // ADDI x0,x0,0
    localparam rv_word nop_instr = 32'h0000_0013;
    localparam int unsigned num_regs = 32;
    // every write is a full word
    localparam logic [3:0] word_mbe = 4'b1111;
    localparam rv_word pc_step = 32'd4;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // same encoding as the branch funct3 field
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic {
        a_rs1,
        a_pc
    } op_a_sel_e;

    typedef enum logic {
        b_rs2,
        b_imm
    } op_b_sel_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc4
    } wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        cmp_op_e   cmp_op;
        op_a_sel_e a_sel;
        op_b_sel_e b_sel;
        wb_sel_e   wb_sel;
        reg_idx    rs1;
        reg_idx    rs2;
        reg_idx    rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        rv_word    imm;
        rv_word    pc;
        logic      valid;
    } ctrl_word_s;

    typedef struct packed {
        reg_idx  rd;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        wb_sel_e wb_sel;
        rv_word  alu_result;
        rv_word  store_data;
        rv_word  pc_plus4;
    } ex_mem_s;

    typedef struct packed {
        reg_idx  rd;
        logic    reg_write;
        wb_sel_e wb_sel;
        rv_word  alu_result;
        rv_word  load_data;
        rv_word  pc_plus4;
    } mem_wb_s;

endpackage

`default_nettype wire
